//--- Bender.yml
package:
  name: rv_int_pipe

sources:
  - files:
      - hdl/rv_core_pkg.sv
      - hdl/rv_reg_file.sv
      - hdl/rv_decode_stage.sv
      - hdl/rv_operand_stage.sv
      - hdl/rv_execute_stage.sv
      - hdl/rv_int_pipe.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_rv_int_pipe.sv

//--- hdl/rv_core_pkg.sv
// RV32I integer pipeline definitions
package rv_core_pkg;

    // Data path and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // j-to-self, used as the halt marker
    localparam logic [31:0] HALT_INSN = 32'h0000006f;

    // Privileged SYSTEM encodings held in the I-immediate field
    localparam logic [11:0] PRIV_ECALL  = 12'h000;
    localparam logic [11:0] PRIV_EBREAK = 12'h001;
    localparam logic [11:0] PRIV_WFI    = 12'h105;
    localparam logic [11:0] PRIV_MRET   = 12'h302;

    typedef enum logic [6:0] {
        LUI     = 7'b0110111,
        AUIPC   = 7'b0010111,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        BRANCH  = 7'b1100011,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        IMMED   = 7'b0010011,
        REGREG  = 7'b0110011,
        MISCMEM = 7'b0001111,
        SYSTEM  = 7'b1110011
    } opcode_t;

    // Shared by REGREG and IMMED
    typedef enum logic [2:0] {
        F3_ADDSUB = 3'b000,
        F3_SLL    = 3'b001,
        F3_SLT    = 3'b010,
        F3_SLTU   = 3'b011,
        F3_XOR    = 3'b100,
        F3_SR     = 3'b101,
        F3_OR     = 3'b110,
        F3_AND    = 3'b111
    } funct3_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic {A_RS1, A_PC} a_sel_t;

    typedef enum logic [1:0] {B_RS2, B_IMM, B_ZERO} b_sel_t;

    typedef enum logic [2:0] {
        TRAP_NONE, TRAP_ILLEGAL, TRAP_ECALL, TRAP_EBREAK, TRAP_MRET, TRAP_WFI
    } trap_t;

    // Decode to operand stage
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        a_sel_t                a_sel;
        b_sel_t                b_sel;
        alu_op_t               alu_op;
        logic                  wen;
        trap_t                 trap;
        logic                  halt;
    } decoded_t;

    // Operand to execute stage
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_t               alu_op;
        logic                  wen;
        trap_t                 trap;
        logic                  halt;
    } operands_t;

    // Writeback port, also the register file write
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        logic                  wen;
        trap_t                 trap;
        logic                  halt;
        logic [XLEN-1:0]       pc;
    } retire_t;

endpackage

//--- hdl/rv_decode_stage.sv
// RV32I instruction decoder
`timescale 1ns/1ns

module rv_decode_stage import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] pc_i,
    output decoded_t    dec_o
);

    opcode_t         opcode;
    funct3_t         funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_shamt;
    logic            is_illegal;
    logic            is_ecall;
    logic            is_ebreak;
    logic            is_mret;
    logic            is_wfi;
    logic            reads_rs1;
    logic            reads_rs2;
    decoded_t        dec_d;

    // Bit 30 only selects SUB for register forms; in ADDI it is immediate
    function automatic alu_op_t alu_op_for(input funct3_t f3, input logic alt,
                                           input logic is_reg);
        case (f3)
            F3_ADDSUB: return (alt && is_reg) ? ALU_SUB : ALU_ADD;
            F3_SLL:    return ALU_SLL;
            F3_SLT:    return ALU_SLT;
            F3_SLTU:   return ALU_SLTU;
            F3_XOR:    return ALU_XOR;
            F3_SR:     return alt ? ALU_SRA : ALU_SRL;
            F3_OR:     return ALU_OR;
            default:   return ALU_AND;
        endcase
    endfunction

    assign opcode    = opcode_t'(instr_i[6:0]);
    assign funct3    = funct3_t'(instr_i[14:12]);
    assign funct7    = instr_i[31:25];
    assign imm_i     = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u     = {instr_i[31:12], 12'b0};
    assign imm_shamt = {27'b0, instr_i[24:20]};

    always_comb begin
        dec_d.a_sel  = A_RS1;
        dec_d.b_sel  = B_IMM;
        dec_d.alu_op = ALU_ADD;
        dec_d.imm    = imm_i;
        dec_d.wen    = 1'b0;
        reads_rs1    = 1'b0;
        reads_rs2    = 1'b0;
        is_illegal   = 1'b0;
        is_ecall     = 1'b0;
        is_ebreak    = 1'b0;
        is_mret      = 1'b0;
        is_wfi       = 1'b0;

        case (opcode)
            REGREG: begin
                // funct7[0] would be the M extension
                if (funct7[0]) begin
                    is_illegal = 1'b1;
                end else begin
                    dec_d.b_sel  = B_RS2;
                    dec_d.alu_op = alu_op_for(funct3, instr_i[30], 1'b1);
                    dec_d.wen    = 1'b1;
                    reads_rs1    = 1'b1;
                    reads_rs2    = 1'b1;
                end
            end
            IMMED: begin
                dec_d.alu_op = alu_op_for(funct3, instr_i[30], 1'b0);
                if (funct3 == F3_SLL || funct3 == F3_SR) dec_d.imm = imm_shamt;
                dec_d.wen = 1'b1;
                reads_rs1 = 1'b1;
            end
            // rs1 stays x0, so operand a is zero
            LUI: begin
                dec_d.imm = imm_u;
                dec_d.wen = 1'b1;
            end
            AUIPC: begin
                dec_d.a_sel = A_PC;
                dec_d.imm   = imm_u;
                dec_d.wen   = 1'b1;
            end
            SYSTEM: begin
                // Only the PRIV group; CSR forms are not supported
                if (funct3 == F3_ADDSUB && instr_i[19:15] == '0 && instr_i[11:7] == '0) begin
                    case (instr_i[31:20])
                        PRIV_ECALL:  is_ecall = 1'b1;
                        PRIV_EBREAK: is_ebreak = 1'b1;
                        PRIV_MRET:   is_mret = 1'b1;
                        PRIV_WFI:    is_wfi = 1'b1;
                        default:     is_illegal = 1'b1;
                    endcase
                end else begin
                    is_illegal = 1'b1;
                end
            end
            default: is_illegal = 1'b1;
        endcase

        if (is_illegal)     dec_d.trap = TRAP_ILLEGAL;
        else if (is_ecall)  dec_d.trap = TRAP_ECALL;
        else if (is_ebreak) dec_d.trap = TRAP_EBREAK;
        else if (is_mret)   dec_d.trap = TRAP_MRET;
        else if (is_wfi)    dec_d.trap = TRAP_WFI;
        else                dec_d.trap = TRAP_NONE;

        // Traps retire with zero data and no write
        if (dec_d.trap != TRAP_NONE) begin
            dec_d.b_sel = B_ZERO;
            dec_d.wen   = 1'b0;
        end

        dec_d.valid = instr_valid_i;
        dec_d.pc    = pc_i;
        dec_d.rd    = instr_i[11:7];
        dec_d.rs1   = reads_rs1 ? instr_i[19:15] : '0;
        dec_d.rs2   = reads_rs2 ? instr_i[24:20] : '0;
        dec_d.wen   = dec_d.wen && instr_valid_i && (dec_d.rd != '0);
        dec_d.halt  = instr_valid_i && (instr_i == HALT_INSN);
        if (!instr_valid_i) dec_d.trap = TRAP_NONE;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_o.valid <= 1'b0;
            dec_o.wen   <= 1'b0;
            dec_o.trap  <= TRAP_NONE;
            dec_o.halt  <= 1'b0;
        end else begin
            dec_o <= dec_d;
        end
    end

    a_trap_kind_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        instr_valid_i |-> $onehot0({is_illegal, is_ecall, is_ebreak, is_mret, is_wfi}));

    a_trap_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        (dec_o.trap != TRAP_NONE) |-> !dec_o.wen);

endmodule

//--- hdl/rv_execute_stage.sv
// ALU and retire register
`timescale 1ns/1ns

module rv_execute_stage import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  operands_t ops_i,
    output retire_t   ex_fwd_o,
    output retire_t   retire_o
);

    logic [XLEN-1:0] result;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    assign shamt       = ops_i.b[4:0];
    assign lt_signed   = $signed(ops_i.a) < $signed(ops_i.b);
    assign lt_unsigned = ops_i.a < ops_i.b;

    always_comb begin
        case (ops_i.alu_op)
            ALU_ADD:  result = ops_i.a + ops_i.b;
            ALU_SUB:  result = ops_i.a - ops_i.b;
            ALU_SLL:  result = ops_i.a << shamt;
            ALU_SRL:  result = ops_i.a >> shamt;
            ALU_SRA:  result = $signed(ops_i.a) >>> shamt;
            ALU_AND:  result = ops_i.a & ops_i.b;
            ALU_OR:   result = ops_i.a | ops_i.b;
            ALU_XOR:  result = ops_i.a ^ ops_i.b;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            default:  result = '0;
        endcase
    end

    // Offered to the operand stage before the retire register
    always_comb begin
        ex_fwd_o.valid = ops_i.valid;
        ex_fwd_o.rd    = ops_i.rd;
        ex_fwd_o.data  = result;
        ex_fwd_o.wen   = ops_i.wen;
        ex_fwd_o.trap  = ops_i.trap;
        ex_fwd_o.halt  = ops_i.halt;
        ex_fwd_o.pc    = ops_i.pc;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retire_o.valid <= 1'b0;
            retire_o.wen   <= 1'b0;
            retire_o.trap  <= TRAP_NONE;
            retire_o.halt  <= 1'b0;
        end else begin
            retire_o <= ex_fwd_o;
        end
    end

    a_retire_follows: assert property (@(posedge clk) disable iff (!rst_n_i)
        ops_i.valid |=> retire_o.valid);

endmodule

//--- hdl/rv_int_pipe.sv
// RV32I integer pipeline top
`timescale 1ns/1ns

module rv_int_pipe import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] pc_i,
    output retire_t     retire_o
);

    decoded_t              dec;
    operands_t             ops;
    retire_t               ex_fwd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       rdata1;
    logic [XLEN-1:0]       rdata2;

    rv_decode_stage DECODE (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .dec_o         (dec)
    );

    // Written from the retire register one edge after retirement
    rv_reg_file REG_FILE (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .wr_i     (retire_o)
    );

    rv_operand_stage OPERAND (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .dec_i    (dec),
        .rdata1_i (rdata1),
        .rdata2_i (rdata2),
        .ex_fwd_i (ex_fwd),
        .wb_fwd_i (retire_o),
        .rs1_o    (rs1),
        .rs2_o    (rs2),
        .ops_o    (ops)
    );

    rv_execute_stage EXECUTE (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .ops_i    (ops),
        .ex_fwd_o (ex_fwd),
        .retire_o (retire_o)
    );

endmodule

//--- hdl/rv_operand_stage.sv
// Register read, forwarding and operand select
`timescale 1ns/1ns

module rv_operand_stage import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  decoded_t              dec_i,
    input  logic [XLEN-1:0]       rdata1_i,
    input  logic [XLEN-1:0]       rdata2_i,
    input  retire_t               ex_fwd_i,
    input  retire_t               wb_fwd_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output operands_t             ops_o
);

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    operands_t       ops_d;

    // Execute result is younger than the retire register, so it wins
    function automatic logic [XLEN-1:0] resolve(input logic [REG_ADDR_W-1:0] rs,
                                                input logic [XLEN-1:0] rf_val,
                                                input retire_t ex,
                                                input retire_t wb);
        if (ex.valid && ex.wen && ex.rd == rs) return ex.data;
        if (wb.valid && wb.wen && wb.rd == rs) return wb.data;
        return rf_val;
    endfunction

    assign rs1_o = dec_i.rs1;
    assign rs2_o = dec_i.rs2;

    assign rs1_val = resolve(dec_i.rs1, rdata1_i, ex_fwd_i, wb_fwd_i);
    assign rs2_val = resolve(dec_i.rs2, rdata2_i, ex_fwd_i, wb_fwd_i);

    always_comb begin
        ops_d.valid  = dec_i.valid;
        ops_d.pc     = dec_i.pc;
        ops_d.rd     = dec_i.rd;
        ops_d.alu_op = dec_i.alu_op;
        ops_d.wen    = dec_i.wen;
        ops_d.trap   = dec_i.trap;
        ops_d.halt   = dec_i.halt;
        ops_d.a      = (dec_i.a_sel == A_PC) ? dec_i.pc : rs1_val;
        case (dec_i.b_sel)
            B_RS2:   ops_d.b = rs2_val;
            B_IMM:   ops_d.b = dec_i.imm;
            default: ops_d.b = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ops_o.valid <= 1'b0;
            ops_o.wen   <= 1'b0;
            ops_o.trap  <= TRAP_NONE;
            ops_o.halt  <= 1'b0;
        end else begin
            ops_o <= ops_d;
        end
    end

endmodule

//--- hdl/rv_reg_file.sv
// 32 entry integer register file
`timescale 1ns/1ns

module rv_reg_file import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o,
    input  retire_t               wr_i
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.valid && wr_i.wen && wr_i.rd != '0) begin
            regs[wr_i.rd] <= wr_i.data;
        end
    end

    // x0 is hardwired
    assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

    // Decoder clears wen for rd of zero
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        (wr_i.valid && wr_i.wen) |-> (wr_i.rd != '0));

endmodule

//--- sim/tb_rv_model.svh
// Integer pipeline reference model
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

logic [31:0] model_regs [32] = '{default: '0};

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rd, op};
endfunction

// RV32I integer semantics by funct3
function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic sub,
                                        input logic sra, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
        3'd0: return sub ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            if (sra) return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// Expected retirement that also advances the model registers in program order
function automatic retire_t predict(input logic [31:0] insn, input logic [31:0] pc);
    retire_t     r;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    rd    = insn[11:7];
    f3    = insn[14:12];
    a     = model_regs[insn[19:15]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_u = {insn[31:12], 12'b0};
    r       = '0;
    r.valid = 1'b1;
    r.rd    = rd;
    r.pc    = pc;
    r.trap  = TRAP_NONE;
    r.halt  = (insn == HALT_INSN);
    case (insn[6:0])
        7'h33: begin
            if (insn[25]) r.trap = TRAP_ILLEGAL;
            else r.data = ref_alu(f3, insn[30], insn[30], a, model_regs[insn[24:20]]);
        end
        // Shifts only look at imm[4:0]
        7'h13: r.data = ref_alu(f3, 1'b0, insn[30], a, imm_i);
        7'h37: r.data = imm_u;
        7'h17: r.data = pc + imm_u;
        7'h73: begin
            r.trap = TRAP_ILLEGAL;
            // rs1, funct3 and rd all zero
            if (insn[19:7] == 13'd0) begin
                case (insn[31:20])
                    12'h000: r.trap = TRAP_ECALL;
                    12'h001: r.trap = TRAP_EBREAK;
                    12'h302: r.trap = TRAP_MRET;
                    12'h105: r.trap = TRAP_WFI;
                    default: r.trap = TRAP_ILLEGAL;
                endcase
            end
        end
        default: r.trap = TRAP_ILLEGAL;
    endcase
    r.wen = (r.trap == TRAP_NONE) && (rd != 5'd0);
    if (r.wen) model_regs[rd] = r.data;
    return r;
endfunction

`endif

//--- sim/tb_rv_int_pipe.sv
// Integer pipeline testbench
`timescale 1ns/1ns

module tb_rv_int_pipe import rv_core_pkg::*; ();

    localparam int RESET_CYCLES = 5;
    // Issued instructions plus about four cycles of drain each
    localparam int LEN_RESET    = RESET_CYCLES + 6;
    localparam int LEN_LATENCY  = 8;
    localparam int LEN_ALU      = 38;
    localparam int LEN_FWD      = 22;
    localparam int LEN_TRAP     = 18;
    localparam int LEN_RANDOM   = 206;
    localparam int CYCLE_LIMIT  = LEN_RESET + LEN_LATENCY + LEN_ALU + LEN_FWD + LEN_TRAP
                                  + LEN_RANDOM + 50;

    logic        clk;
    logic        rst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    retire_t     retire_o;

    retire_t     exp_q [$];
    string       name_q [$];
    int          due_q [$];
    string       test_name;
    int          cycle = 0;
    int          pass_count = 0;
    int          err_count = 0;
    int          test_errs = 0;
    logic [31:0] rng = 32'he9dd;
    logic [31:0] next_pc = 32'h0000_1000;

    `include "tb_rv_model.svh"

    rv_int_pipe UUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .retire_o      (retire_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d expected retirements outstanding",
                     CYCLE_LIMIT, exp_q.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic string describe(input retire_t r);
        return $sformatf("rd=%0d data=%h wen=%b trap=%0d halt=%b pc=%h",
                         r.rd, r.data, r.wen, r.trap, r.halt, r.pc);
    endfunction

    // Only x0..x7 so that hazards and rd = 0 come up often
    function automatic logic [31:0] random_insn(input logic [31:0] r);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] sys;
        rd  = {2'b0, r[2:0]};
        rs1 = {2'b0, r[5:3]};
        sys = r[11] ? (r[10] ? 12'h302 : 12'h105) : {11'b0, r[10]};
        case (r[9:7])
            3'd0, 3'd1: return enc_r({1'b0, r[30], 4'b0, r[29] & r[28]}, {2'b0, r[12:10]},
                                     rs1, r[15:13], rd);
            3'd2, 3'd3: return enc_i(r[31:20], rs1, r[15:13], rd, 7'h13);
            3'd4:       return enc_u(r[31:12], rd, r[6] ? 7'h37 : 7'h17);
            3'd5:       return enc_i(sys, 5'd0, 3'd0, r[6] ? rd : 5'd0, 7'h73);
            3'd6:       return {r[31:7], r[6] ? 7'h23 : 7'h63};
            default:    return r[6] ? HALT_INSN : {r[31:7], 7'h03};
        endcase
    endfunction

    task automatic issue(input logic [31:0] insn);
        @(posedge clk);
        #10;
        instr_valid_i = 1'b1;
        instr_i       = insn;
        pc_i          = next_pc;
        exp_q.push_back(predict(insn, next_pc));
        name_q.push_back(test_name);
        // Retire register loads it on the third edge from here
        due_q.push_back(cycle + 3);
        next_pc = next_pc + 4;
    endtask

    task automatic bubble();
        @(posedge clk);
        #10;
        instr_valid_i = 1'b0;
        instr_i       = '0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = err_count;
    endtask

    task automatic finish_test();
        bubble();
        while (exp_q.size() != 0) @(posedge clk);
        $display("%-8s done, %0d errors", test_name, err_count - test_errs);
    endtask

    // Compare at the falling edge where retire_o is stable
    always @(negedge clk) begin : compare
        retire_t want;
        string   name;
        int      due;
        if (!rst_n_i || retire_o.valid !== 1'b1) begin
            if (retire_o.valid !== 1'b0 || retire_o.wen !== 1'b0 || retire_o.halt !== 1'b0) begin
                $display("Retire port active or unknown at cycle %0d outside a retirement",
                         cycle);
                err_count++;
            end
        end else if (exp_q.size() == 0) begin
            $display("Retirement of pc %h at cycle %0d with no instruction outstanding",
                     retire_o.pc, cycle);
            err_count++;
        end else begin
            want = exp_q.pop_front();
            name = name_q.pop_front();
            due  = due_q.pop_front();
            if (cycle != due) begin
                $display("[ERROR] %s latency: expected cycle %0d, actual cycle %0d",
                         name, due, cycle);
                err_count++;
            end
            if (retire_o !== want) begin
                $display("[ERROR] %s: expected %s, actual %s",
                         name, describe(want), describe(retire_o));
                err_count++;
            end else begin
                pass_count++;
            end
        end
    end

    task automatic alu_test();
        start_test("alu");
        issue(enc_u(20'h80000, 5'd1, 7'h37));
        issue(enc_i(12'hfff, 5'd0, 3'd0, 5'd2, 7'h13));
        issue(enc_i(12'hfff, 5'd1, 3'd0, 5'd3, 7'h13));
        issue(enc_i(12'd31, 5'd0, 3'd0, 5'd4, 7'h13));
        for (int f3 = 0; f3 < 8; f3++) begin
            issue(enc_r(7'h00, 5'd3, 5'd1, f3[2:0], 5'd5));
            // Bit 30 set selects SUB and SRA and is ignored by the others
            issue(enc_r(7'h20, 5'd4, 5'd2, f3[2:0], 5'd6));
            issue(enc_i(12'h801, 5'd1, f3[2:0], 5'd7, 7'h13));
        end
        issue(enc_i(12'h41f, 5'd1, 3'd5, 5'd8, 7'h13));
        issue(enc_u(20'hfffff, 5'd9, 7'h17));
        finish_test();
    endtask

    task automatic forward_test();
        start_test("forward");
        issue(enc_i(12'd1, 5'd0, 3'd0, 5'd10, 7'h13));
        repeat (4) issue(enc_i(12'd3, 5'd10, 3'd0, 5'd10, 7'h13));
        issue(enc_i(12'd5, 5'd0, 3'd0, 5'd11, 7'h13));
        issue(enc_i(12'd7, 5'd0, 3'd0, 5'd11, 7'h13));
        // Both sources hold x11 and the younger value must win
        issue(enc_r(7'h00, 5'd11, 5'd11, 3'd0, 5'd12));
        repeat (3) begin
            issue(enc_r(7'h20, 5'd10, 5'd12, 3'd0, 5'd12));
            bubble();
        end
        issue(enc_r(7'h00, 5'd12, 5'd10, 3'd4, 5'd0));
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd13));
        finish_test();
    endtask

    task automatic trap_test();
        start_test("trap");
        issue(enc_i(12'h000, 5'd0, 3'd0, 5'd0, 7'h73));
        issue(enc_i(12'h001, 5'd0, 3'd0, 5'd0, 7'h73));
        issue(enc_i(12'h302, 5'd0, 3'd0, 5'd0, 7'h73));
        issue(enc_i(12'h105, 5'd0, 3'd0, 5'd0, 7'h73));
        issue(enc_i(12'h000, 5'd0, 3'd0, 5'd3, 7'h73));
        issue(enc_i(12'h300, 5'd1, 3'd1, 5'd4, 7'h73));
        issue(enc_i(12'h004, 5'd1, 3'd2, 5'd5, 7'h03));
        issue(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd6));
        issue(enc_i(12'h000, 5'd0, 3'd0, 5'd7, 7'h0f));
        issue(HALT_INSN);
        // x6 must still hold its value from before the MUL
        issue(enc_i(12'd0, 5'd6, 3'd0, 5'd8, 7'h13));
        finish_test();
    endtask

    initial begin
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        // A valid halt held during reset must never retire
        instr_valid_i = 1'b1;
        instr_i       = HALT_INSN;
        pc_i          = '0;
        start_test("reset");
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_n_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        repeat (4) bubble();
        finish_test();
        start_test("latency");
        issue(enc_u(20'h12345, 5'd15, 7'h37));
        finish_test();
        alu_test();
        forward_test();
        trap_test();
        start_test("random");
        repeat (200) begin
            rng = xorshift(rng);
            issue(random_insn(rng));
        end
        finish_test();
        $display("Matched retirements: %0d, errors: %0d", pass_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+sim
hdl/rv_core_pkg.sv
hdl/rv_reg_file.sv
hdl/rv_decode_stage.sv
hdl/rv_operand_stage.sv
hdl/rv_execute_stage.sv
hdl/rv_int_pipe.sv
sim/tb_rv_int_pipe.sv
